// File: design/l2_defines.svh
`ifndef L2_DEFINES_SVH
`define L2_DEFINES_SVH

// cache geometry
`define L2_SETS 16
`define L2_WAYS 4
`define L2_INDEX_W 4
// byte offset inside a line, four 32-bit words
`define L2_OFFSET_W 4
`define L2_TAG_W 24
`define L2_WORDS 4

`endif

// File: design/l2_pkg.sv
`include "l2_defines.svh"

package l2_pkg;

    typedef logic [31:0] l2_addr_t;
    typedef logic [31:0] l2_word_t;
    typedef logic [`L2_WORDS-1:0][31:0] l2_line_t;
    typedef logic [1:0] l2_way_t;

    // who is asking
    typedef enum logic [1:0] {
        SRC_NONE,
        SRC_IREAD,
        SRC_DREAD,
        SRC_DWRITE
    } l2_src_e;

    // maintenance opcodes
    typedef enum logic [1:0] {
        OP_IDX_INV,
        OP_IDX_WB_INV,
        OP_HIT_WB_INV
    } l2_op_e;

    typedef struct packed {
        l2_src_e  src;
        l2_addr_t addr;
        l2_word_t wdata;
    } l2_req_t;

    // index forms take the way from addr[1:0]
    typedef struct packed {
        l2_op_e   op;
        l2_addr_t addr;
    } l2_cop_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_COP,
        ST_CHECK_DIRTY,
        ST_WRITEBACK,
        ST_REFILL_REQ,
        ST_REFILL_WAIT,
        ST_MERGE_WRITE
    } l2_state_e;

endpackage

// File: design/l2_tag_array.sv
`timescale 1ns/1ps
`include "l2_defines.svh"

module l2_tag_array
    import l2_pkg::*;
(
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [`L2_INDEX_W-1:0] index,
    input  logic [`L2_TAG_W-1:0]   tag,
    input  l2_way_t                sel_way,
    input  logic                   fill,
    input  logic                   set_dirty,
    input  logic                   invalidate,
    output logic [`L2_WAYS-1:0]    hit,
    output logic                   sel_dirty,
    output logic [`L2_TAG_W-1:0]   sel_tag
);

    logic [`L2_TAG_W-1:0]                tag_mem [`L2_SETS][`L2_WAYS];
    logic [`L2_SETS-1:0][`L2_WAYS-1:0]  valid;
    logic [`L2_SETS-1:0][`L2_WAYS-1:0]  dirty;

    ////////////////////
    // storage

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_mem[index][sel_way] <= tag;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid <= '0;
            dirty <= '0;
        end else if (invalidate) begin
            valid[index][sel_way] <= 1'b0;
            dirty[index][sel_way] <= 1'b0;
        end else if (fill) begin
            // fresh line from memory is clean
            valid[index][sel_way] <= 1'b1;
            dirty[index][sel_way] <= 1'b0;
        end else if (set_dirty) begin
            dirty[index][sel_way] <= 1'b1;
        end
    end

    ////////////////////
    // lookup

    always_comb begin
        for (int w = 0; w < `L2_WAYS; w++) begin
            hit[w] = valid[index][w] && (tag_mem[index][w] == tag);
        end
    end

    // tag of the selected way builds the writeback address
    assign sel_dirty = dirty[index][sel_way];
    assign sel_tag   = tag_mem[index][sel_way];

endmodule

// File: design/l2_plru.sv
`timescale 1ns/1ps
`include "l2_defines.svh"

module l2_plru
    import l2_pkg::*;
(
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [`L2_INDEX_W-1:0] index,
    input  logic                   use_valid,
    input  l2_way_t                use_way,
    output l2_way_t                victim
);

    // bit 0 root, bit 1 picks in ways 0/1, bit 2 picks in ways 2/3
    logic [`L2_SETS-1:0][2:0] tree;
    logic [2:0]               cur;

    assign cur = tree[index];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tree <= '0;
        end else if (use_valid) begin
            // point every bit on the path away from the used way
            tree[index][0] <= ~use_way[1];
            if (use_way[1]) begin
                tree[index][2] <= ~use_way[0];
            end else begin
                tree[index][1] <= ~use_way[0];
            end
        end
    end

    // follow the tree from the root
    assign victim = {cur[0], cur[0] ? cur[2] : cur[1]};

endmodule

// File: design/l2_data_array.sv
`timescale 1ns/1ps
`include "l2_defines.svh"

module l2_data_array
    import l2_pkg::*;
(
    input  logic                   clk,
    input  logic [`L2_INDEX_W-1:0] index,
    input  l2_way_t                way,
    input  logic [1:0]             word_sel,
    input  logic                   word_we,
    input  l2_word_t               wdata,
    input  logic                   line_we,
    input  l2_line_t               wline,
    output l2_line_t               rline
);

    l2_line_t mem [`L2_SETS][`L2_WAYS];

    always_ff @(posedge clk) begin
        // whole line on refill
        if (line_we) begin
            mem[index][way] <= wline;
        end
        // single word on store
        if (word_we) begin
            mem[index][way][word_sel] <= wdata;
        end
    end

    assign rline = mem[index][way];

endmodule

// File: design/l2_ctrl.sv
`timescale 1ns/1ps
`include "l2_defines.svh"

module l2_ctrl
    import l2_pkg::*;
(
    input  logic                   clk,
    input  logic                   rstn,
    input  l2_req_t                req,
    input  logic                   cop_valid,
    input  l2_cop_t                cop,
    output logic                   i_addr_ok,
    output logic                   i_data_ok,
    output logic                   d_addr_ok,
    output logic                   d_data_ok,
    output l2_word_t               rdata,
    output logic                   mem_req_w,
    output logic                   mem_req_r,
    output logic                   mem_rdy,
    output l2_addr_t               mem_addr,
    output l2_line_t               mem_wline,
    input  logic                   mem_addr_ok_w,
    input  logic                   mem_addr_ok_r,
    input  logic                   mem_data_ok,
    input  l2_line_t               mem_rline,
    // lookup, shared by tag array and plru
    output logic [`L2_INDEX_W-1:0] lk_index,
    output logic [`L2_TAG_W-1:0]   lk_tag,
    // tag array
    output l2_way_t                sel_way,
    output logic                   tag_fill,
    output logic                   tag_set_dirty,
    output logic                   tag_inval,
    input  logic [`L2_WAYS-1:0]    hit,
    input  logic                   sel_dirty,
    input  logic [`L2_TAG_W-1:0]   sel_tag,
    // plru
    output logic                   use_valid,
    output l2_way_t                use_way,
    input  l2_way_t                victim,
    // data array
    output l2_way_t                dat_way,
    output logic [1:0]             word_sel,
    output logic                   word_we,
    output l2_word_t               wdata,
    output logic                   line_we,
    output l2_line_t               wline,
    input  l2_line_t               rline
);

    l2_state_e state;
    l2_state_e next_state;
    l2_req_t   req_buf;
    l2_cop_t   cop_buf;
    logic      cop_mode;
    logic      chk_done;
    l2_way_t   chk_way;
    l2_way_t   hit_way;
    l2_way_t   hit_enc;
    l2_way_t   cop_way;
    l2_addr_t  cur_addr;
    logic      any_hit;
    logic      is_write;

    // lowest set bit wins
    function automatic l2_way_t onehot_to_way(input logic [`L2_WAYS-1:0] vec);
        l2_way_t w;
        w = '0;
        for (int i = `L2_WAYS - 1; i >= 0; i--) begin
            if (vec[i]) begin
                w = l2_way_t'(i);
            end
        end
        return w;
    endfunction

    ////////////////////
    // address split

    assign cur_addr  = cop_mode ? cop_buf.addr : req_buf.addr;
    assign lk_index  = cur_addr[`L2_OFFSET_W +: `L2_INDEX_W];
    assign lk_tag    = cur_addr[31 -: `L2_TAG_W];
    assign word_sel  = cur_addr[`L2_OFFSET_W-1:2];
    assign cop_way   = cop_buf.addr[1:0];
    assign any_hit   = |hit;
    assign hit_enc   = onehot_to_way(hit);
    assign is_write  = (req_buf.src == SRC_DWRITE);

    // one way select serves all three storage blocks
    always_comb begin
        case (state)
            ST_LOOKUP: sel_way = hit_enc;
            ST_COP:    sel_way = cop_way;
            default:   sel_way = chk_way;
        endcase
    end

    assign dat_way   = sel_way;
    assign use_way   = sel_way;
    assign wdata     = req_buf.wdata;
    assign wline     = mem_rline;
    assign mem_wline = rline;
    assign rdata     = (state == ST_REFILL_WAIT) ? mem_rline[word_sel] : rline[word_sel];

    // victim tag on writeback, request tag on refill
    assign mem_addr = (state == ST_WRITEBACK) ?
                      {sel_tag, lk_index, {`L2_OFFSET_W{1'b0}}} :
                      {lk_tag, lk_index, {`L2_OFFSET_W{1'b0}}};

    ////////////////////
    // registers

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= ST_IDLE;
            cop_mode <= 1'b0;
            chk_done <= 1'b0;
        end else begin
            state <= next_state;
            if (state == ST_IDLE) begin
                cop_mode <= cop_valid;
            end
            // check takes exactly two cycles
            if (state == ST_CHECK_DIRTY) begin
                chk_done <= ~chk_done;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE) begin
            if (cop_valid) begin
                cop_buf <= cop;
            end else if (req.src != SRC_NONE) begin
                req_buf <= req;
            end
        end
        if (state == ST_COP) begin
            hit_way <= hit_enc;
        end
        // first check cycle registers the way to inspect
        if (state == ST_CHECK_DIRTY && !chk_done) begin
            if (!cop_mode) begin
                chk_way <= victim;
            end else if (cop_buf.op == OP_IDX_WB_INV) begin
                chk_way <= cop_way;
            end else begin
                chk_way <= hit_way;
            end
        end
    end

    ////////////////////
    // FSM

    always_comb begin
        next_state    = state;
        i_addr_ok     = 1'b0;
        d_addr_ok     = 1'b0;
        i_data_ok     = 1'b0;
        d_data_ok     = 1'b0;
        mem_req_w     = 1'b0;
        mem_req_r     = 1'b0;
        mem_rdy       = 1'b0;
        tag_fill      = 1'b0;
        tag_set_dirty = 1'b0;
        tag_inval     = 1'b0;
        use_valid     = 1'b0;
        word_we       = 1'b0;
        line_we       = 1'b0;
        case (state)
            ST_IDLE: begin
                // maintenance wins over a pending request
                if (cop_valid) begin
                    next_state = ST_COP;
                end else if (req.src != SRC_NONE) begin
                    next_state = ST_LOOKUP;
                    i_addr_ok  = (req.src == SRC_IREAD);
                    d_addr_ok  = (req.src != SRC_IREAD);
                end
            end
            ST_LOOKUP: begin
                if (any_hit) begin
                    next_state = ST_IDLE;
                    use_valid  = 1'b1;
                    if (is_write) begin
                        word_we       = 1'b1;
                        tag_set_dirty = 1'b1;
                    end else begin
                        i_data_ok = (req_buf.src == SRC_IREAD);
                        d_data_ok = (req_buf.src == SRC_DREAD);
                    end
                end else begin
                    next_state = ST_CHECK_DIRTY;
                end
            end
            ST_COP: begin
                case (cop_buf.op)
                    OP_IDX_INV: begin
                        // dropped without writeback
                        tag_inval  = 1'b1;
                        next_state = ST_IDLE;
                    end
                    OP_IDX_WB_INV: next_state = ST_CHECK_DIRTY;
                    OP_HIT_WB_INV: next_state = any_hit ? ST_CHECK_DIRTY : ST_IDLE;
                    default:       next_state = ST_IDLE;
                endcase
            end
            ST_CHECK_DIRTY: begin
                if (chk_done) begin
                    if (sel_dirty) begin
                        next_state = ST_WRITEBACK;
                    end else if (cop_mode) begin
                        tag_inval  = 1'b1;
                        next_state = ST_IDLE;
                    end else begin
                        next_state = ST_REFILL_REQ;
                    end
                end
            end
            ST_WRITEBACK: begin
                mem_req_w = 1'b1;
                if (mem_addr_ok_w) begin
                    if (cop_mode) begin
                        tag_inval  = 1'b1;
                        next_state = ST_IDLE;
                    end else begin
                        next_state = ST_REFILL_REQ;
                    end
                end
            end
            ST_REFILL_REQ: begin
                mem_req_r = 1'b1;
                if (mem_addr_ok_r) begin
                    next_state = ST_REFILL_WAIT;
                end
            end
            ST_REFILL_WAIT: begin
                mem_rdy = 1'b1;
                if (mem_data_ok) begin
                    line_we   = 1'b1;
                    tag_fill  = 1'b1;
                    use_valid = 1'b1;
                    if (is_write) begin
                        next_state = ST_MERGE_WRITE;
                    end else begin
                        i_data_ok  = (req_buf.src == SRC_IREAD);
                        d_data_ok  = (req_buf.src == SRC_DREAD);
                        next_state = ST_IDLE;
                    end
                end
            end
            ST_MERGE_WRITE: begin
                // store word lands on top of the refilled line
                word_we       = 1'b1;
                tag_set_dirty = 1'b1;
                next_state    = ST_IDLE;
            end
            default: next_state = ST_IDLE;
        endcase
    end

endmodule

// File: design/l2cache_top.sv
`timescale 1ns/1ps
`include "l2_defines.svh"

module l2cache_top
    import l2_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  l2_req_t  req,
    input  logic     cop_valid,
    input  l2_cop_t  cop,
    output logic     i_addr_ok,
    output logic     i_data_ok,
    output logic     d_addr_ok,
    output logic     d_data_ok,
    output l2_word_t rdata,
    output logic     mem_req_w,
    output logic     mem_req_r,
    output logic     mem_rdy,
    output l2_addr_t mem_addr,
    output l2_line_t mem_wline,
    input  logic     mem_addr_ok_w,
    input  logic     mem_addr_ok_r,
    input  logic     mem_data_ok,
    input  l2_line_t mem_rline
);

    logic [`L2_INDEX_W-1:0] lk_index;
    logic [`L2_TAG_W-1:0]   lk_tag;
    l2_way_t                sel_way;
    logic                   tag_fill;
    logic                   tag_set_dirty;
    logic                   tag_inval;
    logic [`L2_WAYS-1:0]    hit;
    logic                   sel_dirty;
    logic [`L2_TAG_W-1:0]   sel_tag;
    logic                   use_valid;
    l2_way_t                use_way;
    l2_way_t                victim;
    l2_way_t                dat_way;
    logic [1:0]             word_sel;
    logic                   word_we;
    l2_word_t               wdata;
    logic                   line_we;
    l2_line_t               wline;
    l2_line_t               rline;

    ////////////////////
    // lookup side, tags and replacement in parallel

    l2_tag_array i_l2_tag_array (
        .clk        (clk),
        .rstn       (rstn),
        .index      (lk_index),
        .tag        (lk_tag),
        .sel_way    (sel_way),
        .fill       (tag_fill),
        .set_dirty  (tag_set_dirty),
        .invalidate (tag_inval),
        .hit        (hit),
        .sel_dirty  (sel_dirty),
        .sel_tag    (sel_tag)
    );

    l2_plru i_l2_plru (
        .clk       (clk),
        .rstn      (rstn),
        .index     (lk_index),
        .use_valid (use_valid),
        .use_way   (use_way),
        .victim    (victim)
    );

    l2_data_array i_l2_data_array (
        .clk      (clk),
        .index    (lk_index),
        .way      (dat_way),
        .word_sel (word_sel),
        .word_we  (word_we),
        .wdata    (wdata),
        .line_we  (line_we),
        .wline    (wline),
        .rline    (rline)
    );

    ////////////////////
    // controller

    l2_ctrl i_l2_ctrl (
        .clk           (clk),
        .rstn          (rstn),
        .req           (req),
        .cop_valid     (cop_valid),
        .cop           (cop),
        .i_addr_ok     (i_addr_ok),
        .i_data_ok     (i_data_ok),
        .d_addr_ok     (d_addr_ok),
        .d_data_ok     (d_data_ok),
        .rdata         (rdata),
        .mem_req_w     (mem_req_w),
        .mem_req_r     (mem_req_r),
        .mem_rdy       (mem_rdy),
        .mem_addr      (mem_addr),
        .mem_wline     (mem_wline),
        .mem_addr_ok_w (mem_addr_ok_w),
        .mem_addr_ok_r (mem_addr_ok_r),
        .mem_data_ok   (mem_data_ok),
        .mem_rline     (mem_rline),
        .lk_index      (lk_index),
        .lk_tag        (lk_tag),
        .sel_way       (sel_way),
        .tag_fill      (tag_fill),
        .tag_set_dirty (tag_set_dirty),
        .tag_inval     (tag_inval),
        .hit           (hit),
        .sel_dirty     (sel_dirty),
        .sel_tag       (sel_tag),
        .use_valid     (use_valid),
        .use_way       (use_way),
        .victim        (victim),
        .dat_way       (dat_way),
        .word_sel      (word_sel),
        .word_we       (word_we),
        .wdata         (wdata),
        .line_we       (line_we),
        .wline         (wline),
        .rline         (rline)
    );

endmodule

// File: verif/l2cache_properties.sv
`timescale 1ns/1ps

module l2cache_properties
    import l2_pkg::*;
(
    input logic      clk,
    input logic      rstn,
    input l2_state_e state,
    input logic      mem_req_w,
    input logic      mem_req_r,
    input logic      mem_rdy,
    input logic      i_addr_ok,
    input logic      d_addr_ok,
    input logic      i_data_ok,
    input logic      d_data_ok,
    input logic      tag_fill,
    input logic      word_we,
    input logic      line_we
);

    ////////////////////
    // bus side

    a_mem_excl: assert property (@(posedge clk) disable iff (!rstn)
        !(mem_req_w && mem_req_r))
        else $error("memory read and write requested together");

    a_one_data_ok: assert property (@(posedge clk) disable iff (!rstn)
        !(i_data_ok && d_data_ok))
        else $error("both data_ok outputs high");

    // requests are only taken from idle
    a_addr_ok_idle: assert property (@(posedge clk) disable iff (!rstn)
        (i_addr_ok || d_addr_ok) |-> (state == ST_IDLE))
        else $error("addr_ok outside idle");

    ////////////////////
    // reset

    a_reset_quiet: assert property (@(posedge clk) $rose(rstn) |->
        !(mem_req_w || mem_req_r || mem_rdy || i_addr_ok || d_addr_ok ||
          i_data_ok || d_data_ok || tag_fill || word_we || line_we))
        else $error("strobe active in the first cycle after reset");

endmodule

bind l2_ctrl l2cache_properties i_l2cache_properties (.*);

// File: verif/l2cache_tb.sv
`timescale 1ns/1ps
`include "l2_defines.svh"

module l2cache_tb
    import l2_pkg::*;
();

    localparam int MEM_LINES   = 1024;
    localparam int N_ENTRIES   = 38;
    localparam int CYCLE_LIMIT = N_ENTRIES * 40;

    typedef enum logic [1:0] {ENT_REQ, ENT_COP, ENT_MEMCHK} kind_e;
    typedef enum logic [1:0] {DONT_CARE, MUST_HIT, MUST_MISS} outcome_e;

    typedef struct packed {
        kind_e    kind;
        l2_src_e  src;
        l2_op_e   op;
        l2_addr_t addr;
        l2_word_t wdata;
        outcome_e outcome;
    } entry_t;

    logic     clk;
    logic     rstn;
    l2_req_t  req;
    logic     cop_valid;
    l2_cop_t  cop;
    logic     i_addr_ok;
    logic     i_data_ok;
    logic     d_addr_ok;
    logic     d_data_ok;
    l2_word_t rdata;
    logic     mem_req_w;
    logic     mem_req_r;
    logic     mem_rdy;
    l2_addr_t mem_addr;
    l2_line_t mem_wline;
    logic     mem_addr_ok_w;
    logic     mem_addr_ok_r;
    logic     mem_data_ok;
    l2_line_t mem_rline;
    logic     dut_idle;

    l2_line_t mem_model [MEM_LINES];
    l2_word_t golden [MEM_LINES * 4];
    int       seed;
    int       cycles;
    int       refills;

    entry_t tbl [N_ENTRIES] = '{
        // read miss, then hits from both sides
        '{ENT_REQ, SRC_IREAD,  OP_IDX_INV, 32'h0000_0014, 32'h0000_0000, MUST_MISS},
        '{ENT_REQ, SRC_IREAD,  OP_IDX_INV, 32'h0000_0014, 32'h0000_0000, MUST_HIT},
        '{ENT_REQ, SRC_DREAD,  OP_IDX_INV, 32'h0000_0018, 32'h0000_0000, MUST_HIT},
        // write allocate, write hit, untouched word
        '{ENT_REQ, SRC_DWRITE, OP_IDX_INV, 32'h0000_0118, 32'hA5A5_0118, MUST_MISS},
        '{ENT_REQ, SRC_DWRITE, OP_IDX_INV, 32'h0000_011C, 32'hA5A5_011C, MUST_HIT},
        '{ENT_REQ, SRC_DREAD,  OP_IDX_INV, 32'h0000_0118, 32'h0000_0000, MUST_HIT},
        '{ENT_REQ, SRC_DREAD,  OP_IDX_INV, 32'h0000_011C, 32'h0000_0000, MUST_HIT},
        '{ENT_REQ, SRC_IREAD,  OP_IDX_INV, 32'h0000_0110, 32'h0000_0000, MUST_HIT},
        // five tags into set 2
        '{ENT_REQ, SRC_DWRITE, OP_IDX_INV, 32'h0000_0020, 32'h2222_0000, MUST_MISS},
        '{ENT_REQ, SRC_DWRITE, OP_IDX_INV, 32'h0000_0124, 32'h2222_0001, MUST_MISS},
        '{ENT_REQ, SRC_DWRITE, OP_IDX_INV, 32'h0000_0228, 32'h2222_0002, MUST_MISS},
        '{ENT_REQ, SRC_DWRITE, OP_IDX_INV, 32'h0000_032C, 32'h2222_0003, MUST_MISS},
        '{ENT_REQ, SRC_DWRITE, OP_IDX_INV, 32'h0000_0420, 32'h2222_0004, MUST_MISS},
        '{ENT_REQ, SRC_DREAD,  OP_IDX_INV, 32'h0000_0020, 32'h0000_0000, DONT_CARE},
        '{ENT_REQ, SRC_DREAD,  OP_IDX_INV, 32'h0000_0124, 32'h0000_0000, DONT_CARE},
        '{ENT_REQ, SRC_IREAD,  OP_IDX_INV, 32'h0000_0228, 32'h0000_0000, DONT_CARE},
        '{ENT_REQ, SRC_DREAD,  OP_IDX_INV, 32'h0000_032C, 32'h0000_0000, DONT_CARE},
        '{ENT_REQ, SRC_DREAD,  OP_IDX_INV, 32'h0000_0420, 32'h0000_0000, DONT_CARE},
        // fill set 3 dirty, flush every way by index
        '{ENT_REQ, SRC_DWRITE, OP_IDX_INV, 32'h0000_0030, 32'h3333_0000, MUST_MISS},
        '{ENT_REQ, SRC_DWRITE, OP_IDX_INV, 32'h0000_0134, 32'h3333_0001, MUST_MISS},
        '{ENT_REQ, SRC_DWRITE, OP_IDX_INV, 32'h0000_0238, 32'h3333_0002, MUST_MISS},
        '{ENT_REQ, SRC_DWRITE, OP_IDX_INV, 32'h0000_033C, 32'h3333_0003, MUST_MISS},
        '{ENT_COP, SRC_NONE, OP_IDX_WB_INV, 32'h0000_0030, 32'h0000_0000, DONT_CARE},
        '{ENT_COP, SRC_NONE, OP_IDX_WB_INV, 32'h0000_0031, 32'h0000_0000, DONT_CARE},
        '{ENT_COP, SRC_NONE, OP_IDX_WB_INV, 32'h0000_0032, 32'h0000_0000, DONT_CARE},
        '{ENT_COP, SRC_NONE, OP_IDX_WB_INV, 32'h0000_0033, 32'h0000_0000, DONT_CARE},
        '{ENT_MEMCHK, SRC_NONE, OP_IDX_INV, 32'h0000_0030, 32'h0000_0000, DONT_CARE},
        '{ENT_MEMCHK, SRC_NONE, OP_IDX_INV, 32'h0000_0130, 32'h0000_0000, DONT_CARE},
        '{ENT_MEMCHK, SRC_NONE, OP_IDX_INV, 32'h0000_0230, 32'h0000_0000, DONT_CARE},
        '{ENT_MEMCHK, SRC_NONE, OP_IDX_INV, 32'h0000_0330, 32'h0000_0000, DONT_CARE},
        '{ENT_REQ, SRC_DREAD,  OP_IDX_INV, 32'h0000_0030, 32'h0000_0000, MUST_MISS},
        '{ENT_REQ, SRC_DREAD,  OP_IDX_INV, 32'h0000_0238, 32'h0000_0000, MUST_MISS},
        // hit form keeps the store
        '{ENT_REQ, SRC_DWRITE, OP_IDX_INV, 32'h0000_0044, 32'h4444_0044, MUST_MISS},
        '{ENT_COP, SRC_NONE, OP_HIT_WB_INV, 32'h0000_0040, 32'h0000_0000, DONT_CARE},
        '{ENT_REQ, SRC_DREAD,  OP_IDX_INV, 32'h0000_0044, 32'h0000_0000, MUST_MISS},
        // fresh set 5 fills way 0, index invalidate drops the store
        '{ENT_REQ, SRC_DWRITE, OP_IDX_INV, 32'h0000_0058, 32'h5555_0058, MUST_MISS},
        '{ENT_COP, SRC_NONE, OP_IDX_INV,    32'h0000_0050, 32'h0000_0000, DONT_CARE},
        '{ENT_REQ, SRC_DREAD,  OP_IDX_INV, 32'h0000_0058, 32'h0000_0000, MUST_MISS}
    };

    l2cache_top i_l2cache_top (.*);

    assign dut_idle = (i_l2cache_top.i_l2_ctrl.state == ST_IDLE);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: stimulus table not finished after %0d cycles", cycles);
            $display("Regression failed");
            $fatal(1, "timeout");
        end
    end

    ////////////////////
    // compare tasks

    task automatic check_word(input l2_word_t got, input l2_word_t want, input string what);
        if (got !== want) begin
            $display("[ERROR] %0t %s: got %h expected %h", $time, what, got, want);
            $display("Regression failed");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_line(input l2_line_t got, input l2_line_t want, input string what);
        if (got !== want) begin
            $display("[ERROR] %0t %s: got %h expected %h", $time, what, got, want);
            $display("Regression failed");
            $fatal(1, "line mismatch");
        end
    endtask

    task automatic check_bit(input logic got, input logic want, input string what);
        if (got !== want) begin
            $display("[ERROR] %0t %s: got %b expected %b", $time, what, got, want);
            $display("Regression failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    function automatic l2_line_t golden_line(input l2_addr_t addr);
        l2_line_t line;
        for (int w = 0; w < `L2_WORDS; w++) begin
            line[2'(w)] = golden[{addr[13:4], 2'(w)}];
        end
        return line;
    endfunction

    ////////////////////
    // memory model

    initial begin : memory_model
        int       dly;
        l2_addr_t wa;
        l2_addr_t ra;
        l2_line_t wl;
        seed          = 37;
        refills       = 0;
        mem_addr_ok_w = 1'b0;
        mem_addr_ok_r = 1'b0;
        mem_data_ok   = 1'b0;
        mem_rline     = '0;
        for (int i = 0; i < MEM_LINES; i++) begin
            for (int w = 0; w < `L2_WORDS; w++) begin
                mem_model[10'(i)][2'(w)] = $random(seed);
                golden[{10'(i), 2'(w)}]  = mem_model[10'(i)][2'(w)];
            end
        end
        forever begin
            @(negedge clk);
            if (mem_req_w) begin
                wa  = mem_addr;
                wl  = mem_wline;
                dly = $unsigned($random(seed)) % 4;
                repeat (dly) @(posedge clk);
                @(posedge clk);
                mem_addr_ok_w <= 1'b1;
                @(posedge clk);
                mem_addr_ok_w <= 1'b0;
                check_line(wl, golden_line(wa), "writeback line");
                mem_model[wa[13:4]] = wl;
            end else if (mem_req_r) begin
                ra  = mem_addr;
                refills++;
                dly = $unsigned($random(seed)) % 4;
                repeat (dly) @(posedge clk);
                @(posedge clk);
                mem_addr_ok_r <= 1'b1;
                @(posedge clk);
                mem_addr_ok_r <= 1'b0;
                @(negedge clk);
                while (!mem_rdy) @(negedge clk);
                dly = 1 + $unsigned($random(seed)) % 3;
                repeat (dly - 1) @(posedge clk);
                @(posedge clk);
                mem_data_ok <= 1'b1;
                mem_rline   <= mem_model[ra[13:4]];
                @(posedge clk);
                mem_data_ok <= 1'b0;
            end
        end
    end

    ////////////////////
    // stimulus

    task automatic run_request(input entry_t e);
        l2_word_t rd;
        logic     got_i;
        logic     got_d;
        int       t_acc;
        int       t_data;
        int       fills;
        fills  = refills;
        got_i  = 1'b0;
        got_d  = 1'b0;
        rd     = '0;
        t_data = 0;
        @(posedge clk);
        req <= '{e.src, e.addr, e.wdata};
        @(negedge clk);
        while (!(i_addr_ok || d_addr_ok)) @(negedge clk);
        check_bit(i_addr_ok, e.src == SRC_IREAD, "i_addr_ok");
        check_bit(d_addr_ok, e.src != SRC_IREAD, "d_addr_ok");
        t_acc = cycles;
        @(posedge clk);
        req <= '{SRC_NONE, 32'h0, 32'h0};
        @(negedge clk);
        while (!dut_idle) begin
            if (i_data_ok || d_data_ok) begin
                got_i  = i_data_ok;
                got_d  = d_data_ok;
                rd     = rdata;
                t_data = cycles;
            end
            @(negedge clk);
        end
        if (e.src == SRC_DWRITE) begin
            golden[e.addr[13:2]] = e.wdata;
            check_bit(got_i || got_d, 1'b0, "data_ok on a write");
        end else begin
            check_bit(got_i, e.src == SRC_IREAD, "i_data_ok");
            check_bit(got_d, e.src == SRC_DREAD, "d_data_ok");
            check_word(rd, golden[e.addr[13:2]], "read data");
        end
        if (e.outcome == MUST_HIT) begin
            check_bit(refills != fills, 1'b0, "refill on a hit");
            if (e.src != SRC_DWRITE) begin
                check_bit(t_data - t_acc == 1, 1'b1, "hit data_ok one cycle after addr_ok");
            end
        end else if (e.outcome == MUST_MISS) begin
            check_bit(refills != fills, 1'b1, "refill on a miss");
        end
    endtask

    task automatic run_cop(input entry_t e);
        @(posedge clk);
        cop_valid <= 1'b1;
        cop       <= '{e.op, e.addr};
        @(posedge clk);
        cop_valid <= 1'b0;
        @(negedge clk);
        while (!dut_idle) @(negedge clk);
        // dropped line falls back to what memory still holds
        if (e.op == OP_IDX_INV) begin
            for (int w = 0; w < `L2_WORDS; w++) begin
                golden[{e.addr[13:4], 2'(w)}] = mem_model[e.addr[13:4]][2'(w)];
            end
        end
    endtask

    initial begin : stimulus
        clk       = 1'b0;
        rstn      = 1'b0;
        cycles    = 0;
        req       = '0;
        cop_valid = 1'b0;
        cop       = '0;
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        repeat (2) @(posedge clk);
        for (int n = 0; n < N_ENTRIES; n++) begin
            case (tbl[n].kind)
                ENT_REQ: run_request(tbl[n]);
                ENT_COP: run_cop(tbl[n]);
                default: begin
                    check_line(mem_model[tbl[n].addr[13:4]], golden_line(tbl[n].addr),
                               "memory line after flush");
                end
            endcase
        end
        $display("Regression passed");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+design
design/l2_pkg.sv
design/l2_tag_array.sv
design/l2_plru.sv
design/l2_data_array.sv
design/l2_ctrl.sv
design/l2cache_top.sv
verif/l2cache_properties.sv
verif/l2cache_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       := l2cache_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST)) $(wildcard design/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
